// File: src/fetch_pkg.sv
// shared widths, reset pc, opcodes and bus structs for the fetch front end; import where used
package fetch_pkg;

  // datapath widths
  localparam int PC_WD           = 32;
  localparam int INST_WD         = 32;
  localparam int SRAM_DATA_WD    = 64;
  localparam int SRAM_ADDR_WD    = 32;

  // inst sram geometry
  localparam int SRAM_DEPTH_LOG2 = 8;                  // 256 words
  localparam int SRAM_DEPTH      = 1 << SRAM_DEPTH_LOG2;
  localparam int SRAM_BYTE_OFS   = 3;                  // 8 bytes per sram word

  // first fetch address out of reset
  localparam logic [PC_WD-1:0] RESET_PC = 32'h0000_0000;

  // sequential pc step, one 32-bit instruction
  localparam logic [PC_WD-1:0] PC_STEP  = 32'd4;

  // rv32i major opcode field
  localparam int OPC_WD = 7;
  localparam logic [OPC_WD-1:0] OPC_JAL = 7'b110_1111;

  // redirect from predecode back to the pc
  typedef struct packed {
    logic             br_sel;     // take br_target on next pc load
    logic [PC_WD-1:0] br_target;
  } br_bus_t;

  // fetched item handed to decode
  typedef struct packed {
    logic [INST_WD-1:0] inst;
    logic [PC_WD-1:0]   pc;
  } fs_to_ds_bus_t;

  // J-type immediate, sign extended to pc width
  function automatic logic [PC_WD-1:0] j_imm(input logic [INST_WD-1:0] inst);
    logic [20:0] imm;
    imm = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    return {{(PC_WD - 21){imm[20]}}, imm};
  endfunction

endpackage

// File: src/fetch_pc.sv
// program counter register for the fetch stage; loads branch target or pc + 4 when enabled
`timescale 1ns/1ps

module fetch_pc (
  input  logic                         i_clk,
  input  logic                         i_rst_n,
  input  logic                         i_load,     // fetch item leaves this cycle
  input  fetch_pkg::br_bus_t           i_br,
  output logic [fetch_pkg::PC_WD-1:0]  o_pc
);

  import fetch_pkg::*;

  logic [PC_WD-1:0] pc;
  logic [PC_WD-1:0] seq_pc;
  logic [PC_WD-1:0] next_pc;

  assign seq_pc  = pc + PC_STEP;
  assign next_pc = i_br.br_sel ? i_br.br_target : seq_pc; // redirect wins

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      pc <= RESET_PC;
    end else if (i_load) begin
      pc <= next_pc;
    end
  end

  assign o_pc = pc;

endmodule

// File: src/inst_word_select.sv
// forms the inst sram request from the pc and picks the 32-bit instruction from the 64-bit word
`timescale 1ns/1ps

module inst_word_select (
  input  logic                                i_en,
  input  logic [fetch_pkg::PC_WD-1:0]         i_pc,
  output logic [fetch_pkg::INST_WD-1:0]       o_inst,
  // inst sram interface
  output logic                                o_inst_sram_en,
  output logic [fetch_pkg::SRAM_ADDR_WD-1:0]  o_inst_sram_addr,
  input  logic [fetch_pkg::SRAM_DATA_WD-1:0]  i_inst_sram_rdata
);

  import fetch_pkg::*;

  logic upper_half;

  assign o_inst_sram_en   = i_en;
  // word aligned byte address, low bits cleared
  assign o_inst_sram_addr = {i_pc[SRAM_ADDR_WD-1:SRAM_BYTE_OFS], {SRAM_BYTE_OFS{1'b0}}};

  assign upper_half = i_pc[2];            // second instruction of the word

  always_comb begin
    if (upper_half) begin
      o_inst = i_inst_sram_rdata[SRAM_DATA_WD-1:INST_WD];
    end else begin
      o_inst = i_inst_sram_rdata[INST_WD-1:0];
    end
  end

endmodule

// File: src/fetch_stage.sv
// instruction fetch stage; offers one fetch item every second cycle to decode
`timescale 1ns/1ps

module fetch_stage (
  input  logic                                i_clk,
  input  logic                                i_rst_n,
  // branch bus from predecode
  input  fetch_pkg::br_bus_t                  i_br,
  // to decode
  output logic                                o_fs_to_ds_valid,
  output fetch_pkg::fs_to_ds_bus_t            o_fs_to_ds_bus,
  // inst sram interface
  output logic                                o_inst_sram_en,
  output logic [fetch_pkg::SRAM_ADDR_WD-1:0]  o_inst_sram_addr,
  input  logic [fetch_pkg::SRAM_DATA_WD-1:0]  i_inst_sram_rdata
);

  import fetch_pkg::*;

  logic               fs_valid;
  logic               to_fs_valid;
  logic [PC_WD-1:0]   fs_pc;
  logic [INST_WD-1:0] fs_inst;

  assign to_fs_valid = i_rst_n;           // fetch requests run once reset is gone

  // valid toggles each cycle, so an item is offered on alternate cycles
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      fs_valid <= 1'b0;
    end else begin
      fs_valid <= ~fs_valid;
    end
  end

  fetch_pc u_pc (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_load   (fs_valid),                 // advance as the item goes to decode
    .i_br     (i_br),
    .o_pc     (fs_pc)
  );

  inst_word_select u_word_select (
    .i_en               (to_fs_valid),
    .i_pc               (fs_pc),
    .o_inst             (fs_inst),
    .o_inst_sram_en     (o_inst_sram_en),
    .o_inst_sram_addr   (o_inst_sram_addr),
    .i_inst_sram_rdata  (i_inst_sram_rdata)
  );

  // no back-pressure, decode takes every offered item
  assign o_fs_to_ds_valid = fs_valid;

  always_comb begin
    o_fs_to_ds_bus      = '0;
    o_fs_to_ds_bus.inst = fs_inst;
    o_fs_to_ds_bus.pc   = fs_pc;
  end

endmodule

// File: src/predecode.sv
// head of decode; detects JAL on the fetch item, redirects fetch and registers the item
`timescale 1ns/1ps

module predecode (
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  // from fetch
  input  logic                      i_fs_to_ds_valid,
  input  fetch_pkg::fs_to_ds_bus_t  i_fs_to_ds_bus,
  // redirect back to fetch
  output fetch_pkg::br_bus_t        o_br,
  // decode side register
  output logic                      o_id_valid,
  output fetch_pkg::fs_to_ds_bus_t  o_id_bus,
  output logic                      o_id_is_jal
);

  import fetch_pkg::*;

  logic [OPC_WD-1:0]  opcode;
  logic               is_jal;
  logic [PC_WD-1:0]   jal_imm;
  logic [PC_WD-1:0]   jal_target;
  fs_to_ds_bus_t      id_bus;
  logic               id_is_jal;
  logic               id_valid;

  assign opcode     = i_fs_to_ds_bus.inst[OPC_WD-1:0];
  assign is_jal     = (opcode == OPC_JAL);
  assign jal_imm    = j_imm(i_fs_to_ds_bus.inst);
  assign jal_target = i_fs_to_ds_bus.pc + jal_imm;   // pc relative

  // redirect only for a live item
  always_comb begin
    o_br           = '0;
    o_br.br_sel    = i_fs_to_ds_valid && is_jal;
    o_br.br_target = jal_target;
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      id_valid <= 1'b0;
    end else begin
      id_valid <= i_fs_to_ds_valid;        // one cycle pulse per item
    end
  end

  // payload, captured with the item
  always_ff @(posedge i_clk) begin
    if (i_fs_to_ds_valid) begin
      id_bus    <= i_fs_to_ds_bus;
      id_is_jal <= is_jal;
    end
  end

  assign o_id_valid  = id_valid;
  assign o_id_bus    = id_bus;
  assign o_id_is_jal = id_is_jal;

endmodule

// File: src/inst_sram.sv
// instruction memory, 256 x 64 bits; combinational fetch read and a clocked program load port
`timescale 1ns/1ps

module inst_sram (
  input  logic                                   i_clk,
  // fetch read port
  input  logic                                   i_en,
  input  logic [fetch_pkg::SRAM_ADDR_WD-1:0]     i_addr,    // byte address
  output logic [fetch_pkg::SRAM_DATA_WD-1:0]     o_rdata,
  // load port
  input  logic                                   i_load_en,
  input  logic [fetch_pkg::SRAM_DEPTH_LOG2-1:0]  i_load_addr, // word index
  input  logic [fetch_pkg::SRAM_DATA_WD-1:0]     i_load_data
);

  import fetch_pkg::*;

  logic [SRAM_DATA_WD-1:0]    mem [SRAM_DEPTH];
  logic [SRAM_DEPTH_LOG2-1:0] rd_idx;

  // drop byte offset, upper bits wrap onto the array
  assign rd_idx = i_addr[SRAM_DEPTH_LOG2+SRAM_BYTE_OFS-1:SRAM_BYTE_OFS];

  always_comb begin
    if (i_en) begin
      o_rdata = mem[rd_idx];
    end else begin
      o_rdata = '0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_load_en) begin
      mem[i_load_addr] <= i_load_data;
    end
  end

endmodule

// File: src/fetch_top.sv
// fetch front end top; fetch stage, instruction sram and predecode wired together
`timescale 1ns/1ps

module fetch_top (
  input  logic                                   i_clk,
  input  logic                                   i_rst_n,
  // program load
  input  logic                                   i_load_en,
  input  logic [fetch_pkg::SRAM_DEPTH_LOG2-1:0]  i_load_addr,
  input  logic [fetch_pkg::SRAM_DATA_WD-1:0]     i_load_data,
  // to decode
  output logic                                   o_id_valid,
  output fetch_pkg::fs_to_ds_bus_t               o_id_bus,
  output logic                                   o_id_is_jal
);

  import fetch_pkg::*;

  br_bus_t                  br;
  logic                     fs_to_ds_valid;
  fs_to_ds_bus_t            fs_to_ds_bus;
  logic                     inst_sram_en;
  logic [SRAM_ADDR_WD-1:0]  inst_sram_addr;
  logic [SRAM_DATA_WD-1:0]  inst_sram_rdata;

  fetch_stage u_fetch_stage (
    .i_clk              (i_clk),
    .i_rst_n            (i_rst_n),
    .i_br               (br),
    .o_fs_to_ds_valid   (fs_to_ds_valid),
    .o_fs_to_ds_bus     (fs_to_ds_bus),
    .o_inst_sram_en     (inst_sram_en),
    .o_inst_sram_addr   (inst_sram_addr),
    .i_inst_sram_rdata  (inst_sram_rdata)
  );

  inst_sram u_inst_sram (
    .i_clk        (i_clk),
    .i_en         (inst_sram_en),
    .i_addr       (inst_sram_addr),
    .o_rdata      (inst_sram_rdata),
    .i_load_en    (i_load_en),
    .i_load_addr  (i_load_addr),
    .i_load_data  (i_load_data)
  );

  predecode u_predecode (
    .i_clk             (i_clk),
    .i_rst_n           (i_rst_n),
    .i_fs_to_ds_valid  (fs_to_ds_valid),
    .i_fs_to_ds_bus    (fs_to_ds_bus),
    .o_br              (br),
    .o_id_valid        (o_id_valid),
    .o_id_bus          (o_id_bus),
    .o_id_is_jal       (o_id_is_jal)
  );

endmodule

// File: test/fetch_top_asserts.sv
// concurrent checks on decode pacing and pc sequencing; bound to fetch_top
`timescale 1ns/1ps

module fetch_top_asserts (
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  logic                      i_id_valid,
  input  fetch_pkg::fs_to_ds_bus_t  i_id_bus,
  input  logic                      i_id_is_jal
);

  import fetch_pkg::*;

  int               err_cnt = 0;      // read by the testbench
  logic             seen;             // at least one item decoded
  logic [PC_WD-1:0] last_pc;
  logic             last_jal;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      seen <= 1'b0;
    end else if (i_id_valid) begin
      seen <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_id_valid) begin
      last_pc  <= i_id_bus.pc;
      last_jal <= i_id_is_jal;
    end
  end

  a_reset_quiet: assert property (@(posedge i_clk) !i_rst_n |=> !i_id_valid)
    else begin
      $error("o_id_valid high while reset is held");
      err_cnt = err_cnt + 1;
    end

  a_no_back_to_back: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_id_valid |=> !i_id_valid)
    else begin
      $error("o_id_valid high on two consecutive cycles");
      err_cnt = err_cnt + 1;
    end

  a_period: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_id_valid |-> ##2 i_id_valid)
    else begin
      $error("o_id_valid pulse did not repeat after one idle cycle");
      err_cnt = err_cnt + 1;
    end

  // non-jal item is followed by the next sequential pc
  a_seq_pc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_id_valid && seen && !last_jal) |-> (i_id_bus.pc == last_pc + 32'd4))
    else begin
      $error("decoded pc does not follow previous pc plus 4");
      err_cnt = err_cnt + 1;
    end

endmodule

bind fetch_top fetch_top_asserts u_asserts (
  .i_clk        (i_clk),
  .i_rst_n      (i_rst_n),
  .i_id_valid   (o_id_valid),
  .i_id_bus     (o_id_bus),
  .i_id_is_jal  (o_id_is_jal)
);

// File: test/tb_fetch_top.sv
// testbench for fetch_top; loads a looping program in reset and checks every decoded item
`timescale 1ns/1ps

module tb_fetch_top;

  import fetch_pkg::*;

  localparam int RESET_CYCLES = 16;
  localparam int NUM_INSTS    = 12;
  localparam int NUM_WORDS    = NUM_INSTS / 2;
  localparam int NUM_ITEMS    = 40;
  // reset plus two cycles per item, doubled, plus slack
  localparam int MAX_CYCLES   = 2 * (RESET_CYCLES + 2 * NUM_ITEMS) + 58;
  localparam logic [31:0] SEED = 32'h73fd00ac;

  logic                        clk;
  logic                        rst_n;
  logic                        load_en;
  logic [SRAM_DEPTH_LOG2-1:0]  load_addr;
  logic [SRAM_DATA_WD-1:0]     load_data;
  logic                        id_valid;
  fs_to_ds_bus_t               id_bus;
  logic                        id_is_jal;

  // program model, indexed by pc[5:2]
  logic [31:0] model_mem    [16];
  logic [31:0] model_off    [16];
  logic        model_is_jal [16];

  logic [31:0] exp_pc;
  logic        after_jal;
  int          items      = 0;
  int          cycle_cnt  = 0;

  fetch_top i_fetch_top (
    .i_clk        (clk),
    .i_rst_n      (rst_n),
    .i_load_en    (load_en),
    .i_load_addr  (load_addr),
    .i_load_data  (load_data),
    .o_id_valid   (id_valid),
    .o_id_bus     (id_bus),
    .o_id_is_jal  (id_is_jal)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic report_mismatch(input string test, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("mismatch %s expected %h actual %h", test, exp, act);
    $display("SIMULATION FAILED");
    $fatal(1, "value check failed");
  endtask

  // rv32i J-type layout: imm[20|10:1|11|19:12], rd, opcode
  function automatic logic [31:0] encode_jal(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b110_1111};
  endfunction

  function automatic logic [31:0] random_addi();
    logic [31:0] r;
    r = $urandom();
    return {r[31:20], r[19:15], 3'b000, r[11:7], 7'b001_0011};
  endfunction

  task automatic build_program();
    for (int i = 0; i < 16; i++) begin
      model_mem[4'(i)]    = '0;
      model_off[4'(i)]    = 32'd4;
      model_is_jal[4'(i)] = 1'b0;
    end
    for (int i = 0; i < NUM_INSTS; i++) begin
      model_mem[4'(i)] = random_addi();
    end
    model_off[3]    = 32'd20;             // pc 12 -> 32, skips words 2 and 3
    model_is_jal[3] = 1'b1;
    model_mem[3]    = encode_jal(5'd1, model_off[3][20:0]);
    model_off[11]    = 32'hffff_ffd4;     // pc 44 -> 0
    model_is_jal[11] = 1'b1;
    model_mem[11]    = encode_jal(5'd0, model_off[11][20:0]);
  endtask

  task automatic check_item(input string pc_test);
    logic [3:0]  idx;
    logic [31:0] exp_inst;
    logic        exp_jal;
    idx      = exp_pc[5:2];
    exp_inst = model_mem[idx];
    exp_jal  = model_is_jal[idx];
    assert (id_bus.pc == exp_pc) else report_mismatch(pc_test, exp_pc, id_bus.pc);
    assert (id_bus.inst == exp_inst) else report_mismatch("word_select", exp_inst, id_bus.inst);
    assert (id_is_jal == exp_jal)
      else report_mismatch("jal_flag", {31'b0, exp_jal}, {31'b0, id_is_jal});
    after_jal = model_is_jal[idx];
    if (model_is_jal[idx]) begin
      exp_pc = exp_pc + model_off[idx];
    end else begin
      exp_pc = exp_pc + 32'd4;
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: only %0d of %0d items decoded in %0d cycles",
               items, NUM_ITEMS, MAX_CYCLES);
      $display("SIMULATION FAILED");
      $fatal(1, "watchdog expired");
    end
  end

  // stop at the first failed bound assertion
  always @(negedge clk) begin
    if (i_fetch_top.u_asserts.err_cnt != 0) begin
      $display("a bound assertion on fetch_top failed");
      $display("SIMULATION FAILED");
      $fatal(1, "bound assertion failed");
    end
  end

  initial begin
    string pc_test;
    rst_n     = 1'b0;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    exp_pc    = RESET_PC;
    after_jal = 1'b0;
    void'($urandom(SEED));
    build_program();

    // program load while reset is held
    for (int c = 0; c < RESET_CYCLES; c++) begin
      @(negedge clk);
      assert (!id_valid) else report_mismatch("reset", 32'd0, {31'b0, id_valid});
      if (c < NUM_WORDS) begin
        load_en   = 1'b1;
        load_addr = 8'(c);
        load_data = {model_mem[4'(2 * c + 1)], model_mem[4'(2 * c)]};
      end else begin
        load_en = 1'b0;
      end
    end
    rst_n = 1'b1;

    while (items < NUM_ITEMS) begin
      @(negedge clk);
      if (id_valid) begin
        if (items == 0) begin
          pc_test = "reset";
        end else if (after_jal) begin
          pc_test = "jal_redirect";
        end else begin
          pc_test = "sequential";
        end
        check_item(pc_test);
        items++;
      end
    end

    if (i_fetch_top.u_asserts.err_cnt == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("SIMULATION FAILED");
      $fatal(1, "bound assertion failed");
    end
  end

endmodule

// File: tb.f
src/fetch_pkg.sv
src/fetch_pc.sv
src/inst_word_select.sv
src/fetch_stage.sv
src/predecode.sv
src/inst_sram.sv
src/fetch_top.sv
test/fetch_top_asserts.sv
test/tb_fetch_top.sv

// File: run.sh
#!/bin/sh
# build the fetch front end testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_fetch_top \
  -f tb.f \
  -o sim_fetch_top
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

# bound assertions count their failures, the testbench then stops with $fatal
./obj_dir/sim_fetch_top +verilator+error+limit+100
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit "$status"
fi

exit 0
